/* build.f */
logic/spi_axi_pkg.sv
logic/spi_frame_deframer.sv
logic/spi_cmd_fifo.sv
logic/spi_axi_master.sv
logic/spi_axi_bridge.sv
verif/axi_lite_mem_model.sv
verif/spi_axi_bridge_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the bridge testbench with Verilator.
# Exit status is nonzero when compilation or simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f \
    --top-module spi_axi_bridge_tb -Mdir obj_dir -o spi_axi_bridge_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit $status
fi

./obj_dir/spi_axi_bridge_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit $status
fi

exit 0

/* verif/spi_axi_bridge_tb.sv */
// Testbench for the SPI to AXI4-Lite bridge
// Frames come from a table and MISO of each frame carries the previous read
// aclk runs 40x sclk and SPI pins change on the falling aclk edge
module spi_axi_bridge_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import spi_axi_pkg::*;

    localparam int          NROWS      = 15;
    localparam int          SPI_HALF   = 20;
    localparam int          WATCHDOG   = NROWS * 56 * 40 + 2000;
    localparam logic [19:0] HIGH_ADDR  = 20'h4000_0;
    localparam logic [7:0]  OP_UNKNOWN = 8'h55;

    logic aclk = 1'b0;
    logic aresetn, sclk, cs_n, mosi, miso, stall;
    logic stat_cmd_overrun, stat_wr_error, model_done;
    logic [31:0] awaddr, wdata, araddr, rdata, last_araddr;
    logic [3:0]  wstrb, last_wstrb;
    logic [2:0]  awprot, arprot;
    logic [1:0]  bresp, rresp;
    logic awvalid, awready, wvalid, wready, bvalid, arvalid, arready, rvalid;
    logic bready, rready;
    int   wr_count, rd_count;
    int   done_cnt = 0;
    int   err_cnt = 0;
    int   ovr_cnt = 0;

    // Frame table
    string       row_name [NROWS];
    logic [7:0]  row_op [NROWS];
    logic [11:0] row_addr [NROWS];
    logic [31:0] row_data [NROWS];
    logic        row_stall [NROWS];
    logic        row_chk [NROWS];
    logic [31:0] row_word [NROWS];
    logic        row_flag [NROWS];

    always #2 aclk = ~aclk;

    spi_axi_bridge DUT (
        .aclk (aclk), .aresetn (aresetn),
        .sclk (sclk), .cs_n (cs_n), .mosi (mosi), .miso (miso),
        .m_axi_awaddr (awaddr), .m_axi_awprot (awprot), .m_axi_awvalid (awvalid),
        .m_axi_awready (awready), .m_axi_wdata (wdata), .m_axi_wstrb (wstrb),
        .m_axi_wvalid (wvalid), .m_axi_wready (wready), .m_axi_bresp (bresp),
        .m_axi_bvalid (bvalid), .m_axi_bready (bready), .m_axi_araddr (araddr),
        .m_axi_arprot (arprot), .m_axi_arvalid (arvalid), .m_axi_arready (arready),
        .m_axi_rdata (rdata), .m_axi_rresp (rresp), .m_axi_rvalid (rvalid),
        .m_axi_rready (rready), .stat_cmd_overrun (stat_cmd_overrun),
        .stat_wr_error (stat_wr_error)
    );

    axi_lite_mem_model model (
        .aclk (aclk), .aresetn (aresetn), .stall (stall),
        .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
        .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
        .bresp (bresp), .bvalid (bvalid), .araddr (araddr), .arvalid (arvalid),
        .arready (arready), .rdata (rdata), .rresp (rresp), .rvalid (rvalid),
        .done (model_done), .wr_count (wr_count), .rd_count (rd_count),
        .last_araddr (last_araddr), .last_wstrb (last_wstrb)
    );

    // Pulses can land while a frame is still on the wire
    always @(posedge aclk) begin
        if (model_done) done_cnt <= done_cnt + 1;
        if (stat_wr_error) err_cnt <= err_cnt + 1;
        if (stat_cmd_overrun) ovr_cnt <= ovr_cnt + 1;
    end

    initial begin
        repeat (WATCHDOG) @(posedge aclk);
        $display("Watchdog expired before all frames were checked");
        $display("Simulation FAILED");
        $fatal(1);
    end

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    task automatic set_row(input int r, input string name, input logic [7:0] op,
                           input logic [11:0] addr, input logic [31:0] data,
                           input logic stl, input logic chk, input logic [31:0] word,
                           input logic flag);
        row_name[r]  = name;
        row_op[r]    = op;
        row_addr[r]  = addr;
        row_data[r]  = data;
        row_stall[r] = stl;
        row_chk[r]   = chk;
        row_word[r]  = word;
        row_flag[r]  = flag;
    endtask

    // One mode 0 frame with MISO sampled on each rising sclk of the data field
    task automatic send_frame(input logic [7:0] op, input logic [11:0] addr,
                              input logic [31:0] data, output logic [31:0] word);
        logic [55:0] frame;
        frame = {op, 4'h0, addr, data};
        word  = '0;
        @(negedge aclk);
        cs_n = 1'b0;
        for (int k = 0; k < 56; k++) begin
            mosi = frame[55-k];
            repeat (SPI_HALF) @(negedge aclk);
            sclk = 1'b1;
            if (k >= 24) begin
                word = {word[30:0], miso};
            end
            repeat (SPI_HALF) @(negedge aclk);
            sclk = 1'b0;
        end
        repeat (4) @(negedge aclk);
        cs_n = 1'b1;
    endtask

    task automatic wait_done(input string name, input int done0);
        int n;
        n = 0;
        while (done_cnt == done0 && n < 200) begin
            @(negedge aclk);
            n++;
        end
        if (done_cnt == done0) begin
            $display("%s: no AXI completion within 200 cycles", name);
            $display("Simulation FAILED");
            $fatal(1);
        end
        repeat (2) @(negedge aclk);
    endtask

    initial begin
        logic [31:0] word;
        int done0, err0, ovr0, wr0, rd0, base_wr, n;
        logic is_cmd;
        base_wr = -1;
        void'($urandom(32'h247a_e522));
        aresetn = 1'b0;
        sclk    = 1'b0;
        cs_n    = 1'b1;
        mosi    = 1'b0;
        stall   = 1'b0;

        set_row(0, "wr_010", OP_WRITE, 12'h010, 32'h1234_5678, 0, 0, '0, 0);
        set_row(1, "rd_010", OP_READ, 12'h010, '0, 0, 1, READ_ERR_WORD, 0);
        set_row(2, "rd_e00", OP_READ, 12'hE00, '0, 0, 1, 32'h1234_5678, 0);
        set_row(3, "wr_f04", OP_WRITE, 12'hF04, 32'h0BAD_0F04, 0, 1, READ_ERR_WORD, 1);
        set_row(4, "rd_010_again", OP_READ, 12'h010, '0, 0, 1, READ_ERR_WORD, 0);
        set_row(5, "wr_020", OP_WRITE, 12'h020, 32'hCAFE_0020, 0, 1, 32'h1234_5678, 0);
        set_row(6, "op_55", OP_UNKNOWN, 12'h010, 32'hFFFF_0000, 0, 1, 32'h1234_5678, 0);
        set_row(7, "rd_020", OP_READ, 12'h020, '0, 0, 1, 32'h1234_5678, 0);
        set_row(8, "op_00", 8'h00, 12'h000, '0, 0, 1, 32'hCAFE_0020, 0);
        // Six stalled writes where the sixth overflows the FIFO
        for (int i = 0; i < 6; i++) begin
            set_row(9 + i, $sformatf("stall_wr_%0d", i), OP_WRITE, 12'(12'h040 + 4 * i),
                    32'hA000_0000 + i, 1, 0, '0, i == 5);
        end

        repeat (8) @(negedge aclk);
        aresetn = 1'b1;

        for (int r = 0; r < NROWS; r++) begin
            stall = row_stall[r];
            if (row_stall[r] && base_wr < 0) base_wr = wr_count;
            done0 = done_cnt;
            err0  = err_cnt;
            ovr0  = ovr_cnt;
            wr0   = wr_count;
            rd0   = rd_count;
            send_frame(row_op[r], row_addr[r], row_data[r], word);
            if (row_chk[r]) check_word(row_name[r], row_word[r], word);
            is_cmd = (row_op[r] == OP_WRITE || row_op[r] == OP_READ);
            if (is_cmd && !row_stall[r]) begin
                wait_done(row_name[r], done0);
                if (row_op[r] == OP_WRITE) begin
                    check_word(row_name[r], {HIGH_ADDR, row_addr[r]},
                               model.aw_log[wr_count - 1]);
                    check_word(row_name[r], 32'hF, {28'h0, last_wstrb});
                    check_word(row_name[r], 32'h0, {29'h0, awprot});
                    check_flag(row_name[r], 1'b1, bready);
                end else begin
                    check_word(row_name[r], {HIGH_ADDR, row_addr[r]}, last_araddr);
                    check_word(row_name[r], 32'h0, {29'h0, arprot});
                    check_flag(row_name[r], 1'b1, rready);
                end
                check_flag(row_name[r], row_flag[r], err_cnt != err0);
            end else begin
                repeat (200) @(negedge aclk);
                if (row_stall[r]) begin
                    check_flag(row_name[r], row_flag[r], ovr_cnt != ovr0);
                end else begin
                    check_word(row_name[r], 32'(wr0), 32'(wr_count));
                    check_word(row_name[r], 32'(rd0), 32'(rd_count));
                end
            end
        end

        // Release the stall and let five writes drain in order
        stall = 1'b0;
        n = 0;
        while (wr_count < base_wr + 5 && n < 400) begin
            @(negedge aclk);
            n++;
        end
        repeat (20) @(negedge aclk);
        check_word("drain_count", 32'(base_wr + 5), 32'(wr_count));
        for (int i = 0; i < 5; i++) begin
            check_word("drain_order", {HIGH_ADDR, 12'(12'h040 + 4 * i)},
                       model.aw_log[base_wr + i]);
        end
        check_word("overrun_pulses", 32'd1, 32'(ovr_cnt));
        check_word("wr_error_pulses", 32'd1, 32'(err_cnt));

        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* verif/axi_lite_mem_model.sv */
// AXI4-Lite responder for the bridge testbench
// 16-word memory indexed by address bits [5:2]
// Local 0xF00-0xFFF answers SLVERR, 0xE00-0xEFF answers DECERR
// AW and W are taken together, stall holds them off
// Assumes bready and rready are always high
module axi_lite_mem_model (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic        stall,
    input  logic [31:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic [31:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    output logic        done,
    output int          wr_count,
    output int          rd_count,
    output logic [31:0] last_araddr,
    output logic [3:0]  last_wstrb
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] mem [16];
    logic [31:0] aw_log [64];
    logic [1:0]  aw_dly;
    logic [1:0]  ar_dly;

    function automatic logic [1:0] resp_for(input logic [11:0] addr);
        if (addr >= 12'hF00) begin
            return 2'b10;
        end else if (addr >= 12'hE00) begin
            return 2'b11;
        end
        return 2'b00;
    endfunction

    // One completion per bvalid or rvalid beat
    assign done = bvalid || rvalid;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            awready  <= 1'b0;
            wready   <= 1'b0;
            bvalid   <= 1'b0;
            bresp    <= 2'b00;
            arready  <= 1'b0;
            rvalid   <= 1'b0;
            rresp    <= 2'b00;
            rdata    <= '0;
            wr_count <= 0;
            rd_count <= 0;
            aw_dly   <= 2'($urandom_range(3, 0));
            ar_dly   <= 2'($urandom_range(3, 0));
            for (int i = 0; i < 16; i++) begin
                mem[i] <= 32'h5a00_0000 | (i * 32'h0001_0101);
            end
        end else begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;

            // Write channel
            if (awvalid && wvalid && !awready && !bvalid && !stall) begin
                if (aw_dly != 2'd0) begin
                    aw_dly <= aw_dly - 2'd1;
                end else begin
                    awready <= 1'b1;
                    wready  <= 1'b1;
                end
            end
            if (awready) begin
                aw_log[wr_count[5:0]] <= awaddr;
                last_wstrb            <= wstrb;
                wr_count              <= wr_count + 1;
                bvalid                <= 1'b1;
                bresp                 <= resp_for(awaddr[11:0]);
                aw_dly                <= 2'($urandom_range(3, 0));
                if (resp_for(awaddr[11:0]) == 2'b00) begin
                    mem[awaddr[5:2]] <= wdata;
                end
            end

            // Read channel
            if (arvalid && !arready && !rvalid) begin
                if (ar_dly != 2'd0) begin
                    ar_dly <= ar_dly - 2'd1;
                end else begin
                    arready <= 1'b1;
                end
            end
            if (arready) begin
                last_araddr <= araddr;
                rd_count    <= rd_count + 1;
                rvalid      <= 1'b1;
                rresp       <= resp_for(araddr[11:0]);
                rdata       <= mem[araddr[5:2]];
                ar_dly      <= 2'($urandom_range(3, 0));
            end
        end
    end

endmodule

/* logic/spi_axi_bridge.sv */
// SPI slave to AXI4-Lite bridge top level
// aclk must run at least 8x sclk, SPI mode 0 only
// Read results come back on MISO in the frame after the read
module spi_axi_bridge (
    input  logic                           aclk,
    input  logic                           aresetn,
    // SPI pins
    input  logic                           sclk,
    input  logic                           cs_n,
    input  logic                           mosi,
    output logic                           miso,
    // AXI4-Lite master
    output logic [31:0]                    m_axi_awaddr,
    output logic [2:0]                     m_axi_awprot,
    output logic                           m_axi_awvalid,
    input  logic                           m_axi_awready,
    output logic [spi_axi_pkg::DATA_W-1:0] m_axi_wdata,
    output logic [3:0]                     m_axi_wstrb,
    output logic                           m_axi_wvalid,
    input  logic                           m_axi_wready,
    input  logic [1:0]                     m_axi_bresp,
    input  logic                           m_axi_bvalid,
    output logic                           m_axi_bready,
    output logic [31:0]                    m_axi_araddr,
    output logic [2:0]                     m_axi_arprot,
    output logic                           m_axi_arvalid,
    input  logic                           m_axi_arready,
    input  logic [spi_axi_pkg::DATA_W-1:0] m_axi_rdata,
    input  logic [1:0]                     m_axi_rresp,
    input  logic                           m_axi_rvalid,
    output logic                           m_axi_rready,
    // Status pulses
    output logic                           stat_cmd_overrun,
    output logic                           stat_wr_error
);
    import spi_axi_pkg::*;

    logic                    push;
    logic [CMD_W-1:0]        push_cmd;
    logic                    cmd_valid;
    logic                    cmd_ready;
    logic                    cmd_read;
    logic [LOCAL_ADDR_W-1:0] cmd_addr;
    logic [DATA_W-1:0]       cmd_data;
    logic [DATA_W-1:0]       rd_data;

    spi_frame_deframer u_deframer (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .sclk     (sclk),
        .cs_n     (cs_n),
        .mosi     (mosi),
        .miso     (miso),
        .rd_data  (rd_data),
        .push     (push),
        .push_cmd (push_cmd)
    );

    spi_cmd_fifo u_cmd_fifo (
        .aclk             (aclk),
        .aresetn          (aresetn),
        .push             (push),
        .push_cmd         (push_cmd),
        .cmd_ready        (cmd_ready),
        .cmd_valid        (cmd_valid),
        .cmd_read         (cmd_read),
        .cmd_addr         (cmd_addr),
        .cmd_data         (cmd_data),
        .stat_cmd_overrun (stat_cmd_overrun)
    );

    spi_axi_master u_axi_master (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .cmd_valid     (cmd_valid),
        .cmd_read      (cmd_read),
        .cmd_addr      (cmd_addr),
        .cmd_data      (cmd_data),
        .cmd_ready     (cmd_ready),
        .rd_data       (rd_data),
        .stat_wr_error (stat_wr_error),
        .m_axi_awaddr  (m_axi_awaddr),
        .m_axi_awprot  (m_axi_awprot),
        .m_axi_awvalid (m_axi_awvalid),
        .m_axi_awready (m_axi_awready),
        .m_axi_wdata   (m_axi_wdata),
        .m_axi_wstrb   (m_axi_wstrb),
        .m_axi_wvalid  (m_axi_wvalid),
        .m_axi_wready  (m_axi_wready),
        .m_axi_bresp   (m_axi_bresp),
        .m_axi_bvalid  (m_axi_bvalid),
        .m_axi_bready  (m_axi_bready),
        .m_axi_araddr  (m_axi_araddr),
        .m_axi_arprot  (m_axi_arprot),
        .m_axi_arvalid (m_axi_arvalid),
        .m_axi_arready (m_axi_arready),
        .m_axi_rdata   (m_axi_rdata),
        .m_axi_rresp   (m_axi_rresp),
        .m_axi_rvalid  (m_axi_rvalid),
        .m_axi_rready  (m_axi_rready)
    );

endmodule

/* logic/spi_axi_master.sv */
// AXI4-Lite master for one command at a time
// Address is AXI_HIGH_ADDR above the 12-bit local address
// Writes use all byte lanes, prot is always zero
// bready and rready are tied high, responses are never back-pressured
// A failed read leaves READ_ERR_WORD in rd_data
module spi_axi_master (
    input  logic                                 aclk,
    input  logic                                 aresetn,
    // Command side
    input  logic                                 cmd_valid,
    input  logic                                 cmd_read,
    input  logic [spi_axi_pkg::LOCAL_ADDR_W-1:0] cmd_addr,
    input  logic [spi_axi_pkg::DATA_W-1:0]       cmd_data,
    output logic                                 cmd_ready,
    output logic [spi_axi_pkg::DATA_W-1:0]       rd_data,
    output logic                                 stat_wr_error,
    // AXI4-Lite master
    output logic [31:0]                          m_axi_awaddr,
    output logic [2:0]                           m_axi_awprot,
    output logic                                 m_axi_awvalid,
    input  logic                                 m_axi_awready,
    output logic [spi_axi_pkg::DATA_W-1:0]       m_axi_wdata,
    output logic [3:0]                           m_axi_wstrb,
    output logic                                 m_axi_wvalid,
    input  logic                                 m_axi_wready,
    input  logic [1:0]                           m_axi_bresp,
    input  logic                                 m_axi_bvalid,
    output logic                                 m_axi_bready,
    output logic [31:0]                          m_axi_araddr,
    output logic [2:0]                           m_axi_arprot,
    output logic                                 m_axi_arvalid,
    input  logic                                 m_axi_arready,
    input  logic [spi_axi_pkg::DATA_W-1:0]       m_axi_rdata,
    input  logic [1:0]                           m_axi_rresp,
    input  logic                                 m_axi_rvalid,
    output logic                                 m_axi_rready
);
    import spi_axi_pkg::*;

    logic wr_cmd;
    logic rd_cmd;
    logic b_pend;
    logic r_pend;

    assign wr_cmd = cmd_valid && !cmd_read;
    assign rd_cmd = cmd_valid && cmd_read;

    // Busy until every channel of the current command has completed
    assign cmd_ready = !(m_axi_awvalid || m_axi_wvalid || m_axi_arvalid ||
                         b_pend || r_pend);

    // ------------------------------------------------------------------------
    // Write address and data
    // ------------------------------------------------------------------------

    always_ff @(posedge aclk) begin
        if (wr_cmd) begin
            m_axi_awaddr <= {AXI_HIGH_ADDR, cmd_addr};
            m_axi_wdata  <= cmd_data;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            m_axi_awvalid <= 1'b0;
            m_axi_wvalid  <= 1'b0;
        end else begin
            if (wr_cmd) begin
                m_axi_awvalid <= 1'b1;
            end else if (m_axi_awready) begin
                m_axi_awvalid <= 1'b0;
            end
            if (wr_cmd) begin
                m_axi_wvalid <= 1'b1;
            end else if (m_axi_wready) begin
                m_axi_wvalid <= 1'b0;
            end
        end
    end

    assign m_axi_awprot = 3'b000;
    assign m_axi_wstrb  = 4'hF;

    // ------------------------------------------------------------------------
    // Write response
    // ------------------------------------------------------------------------

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            b_pend        <= 1'b0;
            stat_wr_error <= 1'b0;
        end else begin
            if (wr_cmd) begin
                b_pend <= 1'b1;
            end else if (m_axi_bvalid) begin
                b_pend <= 1'b0;
            end
            stat_wr_error <= m_axi_bvalid &&
                             (m_axi_bresp == RESP_SLVERR || m_axi_bresp == RESP_DECERR);
        end
    end

    assign m_axi_bready = 1'b1;

    // ------------------------------------------------------------------------
    // Read address and data
    // ------------------------------------------------------------------------

    always_ff @(posedge aclk) begin
        if (rd_cmd) begin
            m_axi_araddr <= {AXI_HIGH_ADDR, cmd_addr};
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            m_axi_arvalid <= 1'b0;
            r_pend        <= 1'b0;
        end else begin
            if (rd_cmd) begin
                m_axi_arvalid <= 1'b1;
            end else if (m_axi_arready) begin
                m_axi_arvalid <= 1'b0;
            end
            if (rd_cmd) begin
                r_pend <= 1'b1;
            end else if (m_axi_rvalid) begin
                r_pend <= 1'b0;
            end
        end
    end

    // Held until the next read completes
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            rd_data <= READ_ERR_WORD;
        end else if (m_axi_rvalid) begin
            rd_data <= (m_axi_rresp == RESP_OKAY || m_axi_rresp == RESP_EXOKAY) ?
                       m_axi_rdata : READ_ERR_WORD;
        end
    end

    assign m_axi_arprot = 3'b000;
    assign m_axi_rready = 1'b1;

endmodule

/* logic/spi_cmd_fifo.sv */
// Command FIFO between the SPI deframer and the AXI master
// A push into an empty FIFO reaches cmd_valid on the next cycle
// A push while full is dropped and flagged on stat_cmd_overrun
// At most one command is offered per cmd_ready window
module spi_cmd_fifo (
    input  logic                                 aclk,
    input  logic                                 aresetn,
    input  logic                                 push,
    input  logic [spi_axi_pkg::CMD_W-1:0]        push_cmd,
    input  logic                                 cmd_ready,
    output logic                                 cmd_valid,
    output logic                                 cmd_read,
    output logic [spi_axi_pkg::LOCAL_ADDR_W-1:0] cmd_addr,
    output logic [spi_axi_pkg::DATA_W-1:0]       cmd_data,
    output logic                                 stat_cmd_overrun
);
    import spi_axi_pkg::*;

    logic [CMD_W-1:0]      mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W:0]   count;
    logic                  empty;
    logic                  full;
    logic                  pop;
    logic                  bypass;
    logic                  wr_en;
    logic                  rd_en;
    logic [CMD_W-1:0]      head;

    assign empty  = (count == '0);
    assign full   = (count == (FIFO_PTR_W + 1)'(FIFO_DEPTH));
    // Master drops cmd_ready one edge after cmd_valid, so skip that cycle
    assign pop    = cmd_ready && !cmd_valid && (!empty || push);
    assign bypass = pop && empty;
    assign rd_en  = pop && !empty;
    assign wr_en  = push && !bypass && !full;
    assign head   = empty ? push_cmd : mem[rd_ptr];

    always_ff @(posedge aclk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_cmd;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Output register
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            cmd_valid        <= 1'b0;
            stat_cmd_overrun <= 1'b0;
        end else begin
            cmd_valid        <= pop;
            stat_cmd_overrun <= push && full;
        end
    end

    always_ff @(posedge aclk) begin
        if (pop) begin
            {cmd_read, cmd_addr, cmd_data} <= head;
        end
    end

endmodule

/* logic/spi_frame_deframer.sv */
// SPI mode 0 slave, MSB first, fixed 56-bit frames
// All pins are sampled with aclk, which must run at least 8x sclk
// A frame cut short by cs_n rising is dropped without a push
// MISO carries rd_data during the data field, zero elsewhere
// Opcodes other than write and read are discarded at frame end
module spi_frame_deframer (
    input  logic                            aclk,
    input  logic                            aresetn,
    input  logic                            sclk,
    input  logic                            cs_n,
    input  logic                            mosi,
    output logic                            miso,
    input  logic [spi_axi_pkg::DATA_W-1:0]  rd_data,
    output logic                            push,
    output logic [spi_axi_pkg::CMD_W-1:0]   push_cmd
);
    import spi_axi_pkg::*;

    logic [2:0]             sclk_s;
    logic [1:0]             cs_n_s;
    logic [1:0]             mosi_s;
    logic                   sclk_rise;
    logic                   sclk_fall;
    logic                   cs_active;
    logic                   frame_end;
    logic [FRAME_CNT_W-1:0] bit_cnt;
    logic [FRAME_W-2:0]     shift_in;
    logic [FRAME_W-1:0]     frame_next;
    logic [7:0]             opcode;
    logic [DATA_W-1:0]      miso_sr;

    // ------------------------------------------------------------------------
    // Pin synchronizers and sclk edge detect
    // ------------------------------------------------------------------------

    // Third sclk flop only feeds the edge detect
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            sclk_s <= '0;
            cs_n_s <= '1;
            mosi_s <= '0;
        end else begin
            sclk_s <= {sclk_s[1:0], sclk};
            cs_n_s <= {cs_n_s[0], cs_n};
            mosi_s <= {mosi_s[0], mosi};
        end
    end

    assign sclk_rise = sclk_s[1] && !sclk_s[2];
    assign sclk_fall = !sclk_s[1] && sclk_s[2];
    assign cs_active = !cs_n_s[1];

    // ------------------------------------------------------------------------
    // Receive path
    // ------------------------------------------------------------------------

    // Frame as it will look after the current rising edge
    assign frame_next = {shift_in, mosi_s[1]};
    assign opcode     = frame_next[FRAME_W-1 -: 8];
    assign frame_end  = sclk_rise && cs_active &&
                        (bit_cnt == FRAME_CNT_W'(FRAME_W - 1));

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            bit_cnt <= '0;
        end else if (!cs_active) begin
            bit_cnt <= '0;
        end else if (sclk_rise && bit_cnt != FRAME_CNT_W'(FRAME_W)) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (sclk_rise && cs_active) begin
            shift_in <= frame_next[FRAME_W-2:0];
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            push <= 1'b0;
        end else begin
            push <= frame_end && (opcode == OP_WRITE || opcode == OP_READ);
        end
    end

    // Upper four bits of the address field are ignored
    always_ff @(posedge aclk) begin
        if (frame_end) begin
            push_cmd <= {opcode == OP_READ,
                         frame_next[DATA_W +: LOCAL_ADDR_W],
                         frame_next[DATA_W-1:0]};
        end
    end

    // ------------------------------------------------------------------------
    // Transmit path
    // ------------------------------------------------------------------------

    // Load on the falling edge ahead of the first data bit, shift after that
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            miso_sr <= '0;
        end else if (!cs_active) begin
            miso_sr <= '0;
        end else if (sclk_fall) begin
            if (bit_cnt == FRAME_CNT_W'(DATA_START)) begin
                miso_sr <= rd_data;
            end else if (bit_cnt > FRAME_CNT_W'(DATA_START)) begin
                miso_sr <= {miso_sr[DATA_W-2:0], 1'b0};
            end
        end
    end

    assign miso = miso_sr[DATA_W-1];

endmodule

/* logic/spi_axi_pkg.sv */
// Shared constants for the SPI slave to AXI4-Lite bridge
// Frame is 56 bits MSB first: opcode[55:48], address[47:32], data[31:0]
// Only the low LOCAL_ADDR_W address bits reach the AXI side
// FIFO_DEPTH must stay a power of two
package spi_axi_pkg;

    // Frame opcodes
    localparam logic [7:0] OP_WRITE = 8'h02;
    localparam logic [7:0] OP_READ  = 8'h03;

    localparam int LOCAL_ADDR_W = 12;
    localparam int DATA_W       = 32;

    // SPI frame geometry, DATA_START is the first bit of the data field
    localparam int FRAME_W     = 56;
    localparam int DATA_START  = 24;
    localparam int FRAME_CNT_W = $clog2(FRAME_W + 1);

    // Upper AXI address bits above the local 12-bit address
    localparam logic [19:0] AXI_HIGH_ADDR = 20'h4000_0;

    // Command entry is {read flag, address, data}
    localparam int CMD_W      = 1 + LOCAL_ADDR_W + DATA_W;
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    localparam logic [DATA_W-1:0] READ_ERR_WORD = 32'hDEAD_BEEF;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_EXOKAY = 2'b01;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [1:0] RESP_DECERR = 2'b11;

endpackage
